//--- mem_pkg.sv
package mem_pkg;

   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 16;

   // main memory
   localparam int MEM_DEPTH   = 1024;
   localparam int MEM_AW      = $clog2(MEM_DEPTH);  // low address bits used by memory
   localparam int MEM_LAT     = 4;                  // accept to vld, in cycles
   localparam int LAT_W       = $clog2(MEM_LAT + 1);

   localparam logic [DATA_W-1:0] MEM_INIT_KEY = 16'hA5A5;

   // caches, one word per line
   localparam int CACHE_LINES = 16;
   localparam int IDX_W       = $clog2(CACHE_LINES);
   localparam int TAG_W       = ADDR_W - IDX_W;

   // requester -> memory
   typedef struct packed {
      logic              en;     // held until vld
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   // memory -> requester
   typedef struct packed {
      logic              vld;    // one cycle
      logic [DATA_W-1:0] rdata;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      CS_IDLE,
      CS_FILL,
      CS_WRITE
   } cache_state_e;

   typedef enum logic {
      SRC_ICACHE,
      SRC_DCACHE
   } mem_src_e;

endpackage

//--- icache.sv
`timescale 1ns/10ps

module icache (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic [mem_pkg::ADDR_W-1:0]    i_addr,
   output logic [mem_pkg::DATA_W-1:0]    o_instr,
   output logic                          o_busy,
   output mem_pkg::mem_req_t             o_mem_req,
   input  mem_pkg::mem_rsp_t             i_mem_rsp
);

   // line storage
   logic [mem_pkg::DATA_W-1:0]      data_arr [mem_pkg::CACHE_LINES];
   logic [mem_pkg::TAG_W-1:0]       tag_arr  [mem_pkg::CACHE_LINES];
   logic [mem_pkg::CACHE_LINES-1:0] valid;

   mem_pkg::cache_state_e           state;

   logic                            req_en;
   logic [mem_pkg::ADDR_W-1:0]      req_addr;    // address of the outstanding fill

   logic [mem_pkg::IDX_W-1:0]       idx;
   logic [mem_pkg::TAG_W-1:0]       tag;
   logic [mem_pkg::IDX_W-1:0]       fill_idx;
   logic [mem_pkg::TAG_W-1:0]       fill_tag;
   logic                            hit;
   logic                            miss_start;
   logic                            fill_done;

   // lookup on the live address
   assign idx      = i_addr[mem_pkg::IDX_W-1:0];
   assign tag      = i_addr[mem_pkg::ADDR_W-1:mem_pkg::IDX_W];
   assign hit      = valid[idx] && (tag_arr[idx] == tag);

   assign fill_idx = req_addr[mem_pkg::IDX_W-1:0];
   assign fill_tag = req_addr[mem_pkg::ADDR_W-1:mem_pkg::IDX_W];

   assign miss_start = (state == mem_pkg::CS_IDLE) && !hit;
   assign fill_done  = (state == mem_pkg::CS_FILL) && i_mem_rsp.vld;

   assign o_instr = data_arr[idx];
   assign o_busy  = !hit || (state != mem_pkg::CS_IDLE);

   // read only, so wr and wdata stay zero
   assign o_mem_req = '{en: req_en, wr: 1'b0, addr: req_addr, wdata: '0};

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state  <= mem_pkg::CS_IDLE;
         req_en <= 1'b0;
         valid  <= '0;
      end else begin
         case (state)
            mem_pkg::CS_IDLE: begin
               if (miss_start) begin
                  state  <= mem_pkg::CS_FILL;
                  req_en <= 1'b1;
               end
            end
            mem_pkg::CS_FILL: begin
               if (fill_done) begin
                  state           <= mem_pkg::CS_IDLE;
                  req_en          <= 1'b0;     // low the cycle after vld
                  valid[fill_idx] <= 1'b1;
               end
            end
            default: state <= mem_pkg::CS_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (miss_start) begin
         req_addr <= i_addr;
      end
      if (fill_done) begin
         data_arr[fill_idx] <= i_mem_rsp.rdata;
         tag_arr[fill_idx]  <= fill_tag;
      end
   end

endmodule

//--- dcache.sv
`timescale 1ns/10ps

module dcache (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic [mem_pkg::ADDR_W-1:0]    i_addr,
   input  logic [mem_pkg::DATA_W-1:0]    i_wdata,
   input  logic                          i_mem_en,
   input  logic                          i_wrt_en,
   output logic [mem_pkg::DATA_W-1:0]    o_rdata,
   output logic                          o_busy,
   output mem_pkg::mem_req_t             o_mem_req,
   input  mem_pkg::mem_rsp_t             i_mem_rsp
);

   logic [mem_pkg::DATA_W-1:0]      data_arr [mem_pkg::CACHE_LINES];
   logic [mem_pkg::TAG_W-1:0]       tag_arr  [mem_pkg::CACHE_LINES];
   logic [mem_pkg::CACHE_LINES-1:0] valid;

   mem_pkg::cache_state_e           state;

   // outstanding memory transfer
   logic                            req_en;
   logic                            req_wr;
   logic [mem_pkg::ADDR_W-1:0]      req_addr;
   logic [mem_pkg::DATA_W-1:0]      req_wdata;

   logic                            wr_done;     // write finished, waiting for wrt_en to drop

   logic [mem_pkg::IDX_W-1:0]       idx;
   logic [mem_pkg::TAG_W-1:0]       tag;
   logic [mem_pkg::IDX_W-1:0]       line_idx;
   logic [mem_pkg::TAG_W-1:0]       line_tag;
   logic [mem_pkg::DATA_W-1:0]      line_data;
   logic                            hit;
   logic                            rd_miss;
   logic                            wr_start;
   logic                            issue;
   logic                            xfer_done;

   assign idx = i_addr[mem_pkg::IDX_W-1:0];
   assign tag = i_addr[mem_pkg::ADDR_W-1:mem_pkg::IDX_W];
   assign hit = valid[idx] && (tag_arr[idx] == tag);

   assign rd_miss  = i_mem_en && !i_wrt_en && !hit;
   assign wr_start = i_wrt_en && !wr_done;
   assign issue    = (state == mem_pkg::CS_IDLE) && (wr_start || rd_miss);
   assign xfer_done = (state != mem_pkg::CS_IDLE) && i_mem_rsp.vld;

   // line update uses the captured request, not the live inputs
   assign line_idx  = req_addr[mem_pkg::IDX_W-1:0];
   assign line_tag  = req_addr[mem_pkg::ADDR_W-1:mem_pkg::IDX_W];
   assign line_data = (state == mem_pkg::CS_WRITE) ? req_wdata : i_mem_rsp.rdata;

   assign o_rdata   = data_arr[idx];
   assign o_busy    = (state != mem_pkg::CS_IDLE) || rd_miss || wr_start;
   assign o_mem_req = '{en: req_en, wr: req_wr, addr: req_addr, wdata: req_wdata};

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= mem_pkg::CS_IDLE;
         req_en  <= 1'b0;
         wr_done <= 1'b0;
         valid   <= '0;
      end else begin
         if (!i_wrt_en) begin
            wr_done <= 1'b0;
         end
         case (state)
            mem_pkg::CS_IDLE: begin
               if (wr_start) begin                  // writes win over read misses
                  state  <= mem_pkg::CS_WRITE;
                  req_en <= 1'b1;
               end else if (rd_miss) begin
                  state  <= mem_pkg::CS_FILL;
                  req_en <= 1'b1;
               end
            end
            mem_pkg::CS_FILL, mem_pkg::CS_WRITE: begin
               if (xfer_done) begin
                  state           <= mem_pkg::CS_IDLE;
                  req_en          <= 1'b0;
                  valid[line_idx] <= 1'b1;         // write allocates too
                  if (state == mem_pkg::CS_WRITE) begin
                     wr_done <= 1'b1;
                  end
               end
            end
            default: state <= mem_pkg::CS_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (issue) begin
         req_wr    <= wr_start;
         req_addr  <= i_addr;
         req_wdata <= i_wdata;
      end
      if (xfer_done) begin
         data_arr[line_idx] <= line_data;
         tag_arr[line_idx]  <= line_tag;
      end
   end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  mem_pkg::mem_req_t   i_i_req,
   input  mem_pkg::mem_req_t   i_d_req,
   output mem_pkg::mem_rsp_t   o_i_rsp,
   output mem_pkg::mem_rsp_t   o_d_rsp,
   output mem_pkg::mem_req_t   o_mem_req,
   input  mem_pkg::mem_rsp_t   i_mem_rsp
);

   mem_pkg::mem_src_e   grant;    // owner of the transfer in flight
   mem_pkg::mem_src_e   sel;
   logic                locked;

   // icache first when free, otherwise stay with the owner
   always_comb begin
      if (locked) begin
         sel = grant;
      end else if (i_i_req.en) begin
         sel = mem_pkg::SRC_ICACHE;
      end else begin
         sel = mem_pkg::SRC_DCACHE;
      end
   end

   assign o_mem_req = (sel == mem_pkg::SRC_ICACHE) ? i_i_req : i_d_req;

   // the memory is idle whenever we are unlocked, so a forwarded en is accepted
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         locked <= 1'b0;
         grant  <= mem_pkg::SRC_ICACHE;
      end else if (!locked && o_mem_req.en) begin
         locked <= 1'b1;
         grant  <= sel;
      end else if (locked && i_mem_rsp.vld) begin
         locked <= 1'b0;
      end
   end

   // vld only goes to the owner
   assign o_i_rsp = '{vld:   i_mem_rsp.vld && locked && (grant == mem_pkg::SRC_ICACHE),
                      rdata: i_mem_rsp.rdata};
   assign o_d_rsp = '{vld:   i_mem_rsp.vld && locked && (grant == mem_pkg::SRC_DCACHE),
                      rdata: i_mem_rsp.rdata};

endmodule

//--- main_memory.sv
`timescale 1ns/10ps

module main_memory (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  mem_pkg::mem_req_t   i_req,
   output mem_pkg::mem_rsp_t   o_rsp
);

   logic [mem_pkg::DATA_W-1:0]  mem [mem_pkg::MEM_DEPTH];

   logic                        busy;        // counting down an accepted request
   logic [mem_pkg::LAT_W-1:0]   cnt;
   logic                        vld_q;
   logic [mem_pkg::DATA_W-1:0]  rdata_q;

   // captured request
   logic                        wr_q;
   logic [mem_pkg::MEM_AW-1:0]  addr_q;
   logic [mem_pkg::DATA_W-1:0]  wdata_q;

   logic                        accept;
   logic                        done;

   // not during the count and not in the vld cycle, when en is still up
   assign accept = i_req.en && !busy && !vld_q;
   assign done   = busy && (cnt == '0);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy  <= 1'b0;
         cnt   <= '0;
         vld_q <= 1'b0;
      end else begin
         vld_q <= done;
         if (accept) begin
            busy <= 1'b1;
            cnt  <= mem_pkg::LAT_W'(mem_pkg::MEM_LAT - 1);
         end else if (done) begin
            busy <= 1'b0;
         end else if (busy) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         wr_q    <= i_req.wr;
         addr_q  <= i_req.addr[mem_pkg::MEM_AW-1:0];
         wdata_q <= i_req.wdata;
      end
      if (done) begin
         rdata_q <= wr_q ? wdata_q : mem[addr_q];  // write echoes its data
      end
   end

   // known pattern at reset, word k holds k ^ key
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int k = 0; k < mem_pkg::MEM_DEPTH; k++) begin
            mem[k] <= mem_pkg::DATA_W'(k) ^ mem_pkg::MEM_INIT_KEY;
         end
      end else if (done && wr_q) begin
         mem[addr_q] <= wdata_q;
      end
   end

   assign o_rsp = '{vld: vld_q, rdata: rdata_q};

endmodule

//--- memory.sv
`timescale 1ns/10ps

module memory (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic [mem_pkg::ADDR_W-1:0]    i_i_addr,       // fetch address (PC)
   output logic [mem_pkg::DATA_W-1:0]    o_instr,
   output logic                          o_i_busy,
   input  logic [mem_pkg::ADDR_W-1:0]    i_d_addr,
   input  logic [mem_pkg::DATA_W-1:0]    i_d_wdata,
   input  logic                          i_d_mem_en,     // data read enable
   input  logic                          i_d_wrt_en,
   output logic [mem_pkg::DATA_W-1:0]    o_d_rdata,
   output logic                          o_d_busy
);

   mem_pkg::mem_req_t   i_req;       // icache to arbiter
   mem_pkg::mem_req_t   d_req;       // dcache to arbiter
   mem_pkg::mem_rsp_t   i_rsp;
   mem_pkg::mem_rsp_t   d_rsp;
   mem_pkg::mem_req_t   mm_req;      // arbiter to main memory
   mem_pkg::mem_rsp_t   mm_rsp;

   icache u_icache (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_addr     (i_i_addr),
      .o_instr    (o_instr),
      .o_busy     (o_i_busy),
      .o_mem_req  (i_req),
      .i_mem_rsp  (i_rsp)
   );

   dcache u_dcache (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_addr     (i_d_addr),
      .i_wdata    (i_d_wdata),
      .i_mem_en   (i_d_mem_en),
      .i_wrt_en   (i_d_wrt_en),
      .o_rdata    (o_d_rdata),
      .o_busy     (o_d_busy),
      .o_mem_req  (d_req),
      .i_mem_rsp  (d_rsp)
   );

   mem_arbiter u_arbiter (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_i_req    (i_req),
      .i_d_req    (d_req),
      .o_i_rsp    (i_rsp),
      .o_d_rsp    (d_rsp),
      .o_mem_req  (mm_req),
      .i_mem_rsp  (mm_rsp)
   );

   main_memory u_main_mem (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_req      (mm_req),
      .o_rsp      (mm_rsp)
   );

endmodule

//--- memory_assertions.sv
`timescale 1ns/10ps

module memory_assertions (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  logic                i_d_busy,
   input  mem_pkg::mem_req_t   i_mem_req,   // arbiter to main memory
   input  mem_pkg::mem_rsp_t   i_mem_rsp,
   input  mem_pkg::mem_src_e   i_grant
);

   // requester holds en and fields until vld
   a_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_mem_req.en && !i_mem_rsp.vld |=> i_mem_req.en && $stable(i_mem_req))
      else $error("memory request dropped or changed before vld");

   a_vld_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_mem_rsp.vld |=> !i_mem_rsp.vld)
      else $error("memory vld longer than one cycle");

   // owner fixed once its request is in memory, until its vld
   a_grant_locked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $past(i_mem_req.en && !i_mem_rsp.vld) && !i_mem_rsp.vld |=> $stable(i_grant))
      else $error("arbiter grant changed during a transfer");

   a_reset_idle: assert property (@(posedge i_clk)
      !i_rst_n |-> !i_d_busy)
      else $error("data busy during reset");

endmodule

//--- memory_checker.sv
`timescale 1ns/10ps

module memory_checker (
   input  logic         i_clk,
   input  logic         i_rst_n,
   input  logic [15:0]  i_i_addr,
   input  logic [15:0]  i_instr,
   input  logic [15:0]  i_d_addr,
   input  logic [15:0]  i_d_wdata,
   input  logic [15:0]  i_d_rdata,
   input  logic         i_d_wrt_en,
   input  logic         i_d_busy,
   input  logic         i_stb,       // compare the current row
   input  logic         i_chk_i,
   input  logic         i_chk_d,
   input  logic         i_has_exp,
   input  logic [127:0] i_name,
   input  logic [15:0]  i_exp_i,
   input  logic [15:0]  i_exp_d,
   input  logic         i_done,
   output int           o_pass_cnt,
   output int           o_fail_cnt
);

   logic [15:0] shadow [mem_pkg::MEM_DEPTH];
   logic        d_busy_q;

   initial begin
      o_pass_cnt = 0;
      o_fail_cnt = 0;
      d_busy_q   = 1'b0;
      for (int k = 0; k < mem_pkg::MEM_DEPTH; k++) begin
         shadow[k] = 16'(k) ^ mem_pkg::MEM_INIT_KEY;
      end
   end

   task automatic check_row();
      logic [15:0] exp_i;
      logic [15:0] exp_d;
      exp_i = i_has_exp ? i_exp_i : shadow[i_i_addr[mem_pkg::MEM_AW-1:0]];
      exp_d = i_has_exp ? i_exp_d : shadow[i_d_addr[mem_pkg::MEM_AW-1:0]];
      if (i_chk_i && (i_instr !== exp_i)) begin
         $display("[FAIL] %0s instr expected %h actual %h", i_name, exp_i, i_instr);
         o_fail_cnt++;
      end else if (i_chk_d && (i_d_rdata !== exp_d)) begin
         $display("[FAIL] %0s data expected %h actual %h", i_name, exp_d, i_d_rdata);
         o_fail_cnt++;
      end else begin
         $display("[PASS] %0s", i_name);
         o_pass_cnt++;
      end
   endtask

   // sampled mid-cycle, away from the edges
   always @(negedge i_clk) begin
      if (i_rst_n) begin
         if (d_busy_q && !i_d_busy && i_d_wrt_en) begin
            shadow[i_d_addr[mem_pkg::MEM_AW-1:0]] = i_d_wdata;    // write just completed
         end
         d_busy_q = i_d_busy;
         if (i_stb) begin
            check_row();
         end
      end
      if (i_done) begin
         $display("totals: %0d passed, %0d failed", o_pass_cnt, o_fail_cnt);
      end
   end

endmodule

//--- tb_memory.sv
`timescale 1ns/10ps

module tb_memory;

   typedef enum logic [1:0] {
      K_IFETCH,
      K_DREAD,
      K_DWRITE,
      K_BOTH
   } kind_e;

   // one row of the stimulus table
   typedef struct packed {
      logic [127:0] name;
      kind_e        kind;
      logic [15:0]  iaddr;
      logic [15:0]  daddr;
      logic [15:0]  wdata;
      logic         has_exp;   // low means the checker's shadow decides
      logic [15:0]  exp_i;
      logic [15:0]  exp_d;
   } row_t;

   logic        clk;
   logic        rst_n;
   logic [15:0] i_addr;
   logic [15:0] instr;
   logic        i_busy;
   logic [15:0] d_addr;
   logic [15:0] d_wdata;
   logic        d_mem_en;
   logic        d_wrt_en;
   logic [15:0] d_rdata;
   logic        d_busy;

   row_t        rows[$];
   row_t        cur;
   logic        chk_stb;
   logic        chk_done;
   logic        chk_i;
   logic        chk_d;
   int          pass_cnt;
   int          fail_cnt;
   int          seed;
   bit          hung;
   bit          idle;

   assign chk_i = (cur.kind == K_IFETCH) || (cur.kind == K_BOTH);
   assign chk_d = (cur.kind != K_IFETCH);

   memory u_memory (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_i_addr   (i_addr),
      .o_instr    (instr),
      .o_i_busy   (i_busy),
      .i_d_addr   (d_addr),
      .i_d_wdata  (d_wdata),
      .i_d_mem_en (d_mem_en),
      .i_d_wrt_en (d_wrt_en),
      .o_d_rdata  (d_rdata),
      .o_d_busy   (d_busy)
   );

   memory_checker u_checker (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_i_addr   (i_addr),
      .i_instr    (instr),
      .i_d_addr   (d_addr),
      .i_d_wdata  (d_wdata),
      .i_d_rdata  (d_rdata),
      .i_d_wrt_en (d_wrt_en),
      .i_d_busy   (d_busy),
      .i_stb      (chk_stb),
      .i_chk_i    (chk_i),
      .i_chk_d    (chk_d),
      .i_has_exp  (cur.has_exp),
      .i_name     (cur.name),
      .i_exp_i    (cur.exp_i),
      .i_exp_d    (cur.exp_d),
      .i_done     (chk_done),
      .o_pass_cnt (pass_cnt),
      .o_fail_cnt (fail_cnt)
   );

   bind memory memory_assertions u_assertions (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_d_busy   (o_d_busy),
      .i_mem_req  (mm_req),
      .i_mem_rsp  (mm_rsp),
      .i_grant    (u_arbiter.grant)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset content of a memory word
   function automatic logic [15:0] pattern_word(input logic [15:0] addr);
      return addr ^ mem_pkg::MEM_INIT_KEY;
   endfunction

   task automatic add_row(input logic [127:0] name, input kind_e kind,
                          input logic [15:0] iaddr, input logic [15:0] daddr,
                          input logic [15:0] wdata, input logic has_exp,
                          input logic [15:0] exp_i, input logic [15:0] exp_d);
      row_t r;
      r = '{name: name, kind: kind, iaddr: iaddr, daddr: daddr, wdata: wdata,
            has_exp: has_exp, exp_i: exp_i, exp_d: exp_d};
      rows.push_back(r);
   endtask

   task automatic build_table();
      int          r_val;
      int          r_dat;
      logic [15:0] addr;
      logic [127:0] name;
      add_row("if_miss_010", K_IFETCH, 16'h0010, 16'h0, 16'h0, 1'b1, pattern_word(16'h0010), 16'h0);
      add_row("if_hit_010",  K_IFETCH, 16'h0010, 16'h0, 16'h0, 1'b1, pattern_word(16'h0010), 16'h0);
      add_row("if_miss_123", K_IFETCH, 16'h0123, 16'h0, 16'h0, 1'b1, pattern_word(16'h0123), 16'h0);
      add_row("if_miss_3fe", K_IFETCH, 16'h03FE, 16'h0, 16'h0, 1'b1, pattern_word(16'h03FE), 16'h0);
      add_row("dr_miss_020", K_DREAD,  16'h0, 16'h0020, 16'h0, 1'b1, 16'h0, pattern_word(16'h0020));
      add_row("dr_hit_020",  K_DREAD,  16'h0, 16'h0020, 16'h0, 1'b1, 16'h0, pattern_word(16'h0020));
      add_row("dw_044",      K_DWRITE, 16'h0, 16'h0044, 16'h1234, 1'b1, 16'h0, 16'h1234);
      add_row("dr_044",      K_DREAD,  16'h0, 16'h0044, 16'h0, 1'b1, 16'h0, 16'h1234);
      add_row("dr_alias_054", K_DREAD, 16'h0, 16'h0054, 16'h0, 1'b1, 16'h0, pattern_word(16'h0054));
      add_row("both_miss",   K_BOTH,   16'h0031, 16'h0062, 16'h0, 1'b1,
              pattern_word(16'h0031), pattern_word(16'h0062));
      add_row("dw_200",      K_DWRITE, 16'h0, 16'h0200, 16'hBEEF, 1'b1, 16'h0, 16'hBEEF);
      add_row("if_200",      K_IFETCH, 16'h0200, 16'h0, 16'h0, 1'b1, 16'hBEEF, 16'h0);
      // small address range so reads often land on written or aliased lines
      for (int i = 0; i < 20; i++) begin
         r_val = $random(seed);
         r_dat = $random(seed);
         addr  = 16'(r_val) & 16'h007F;
         name  = {"rnd_", 8'(48 + i / 10), 8'(48 + i % 10)};
         add_row(name, r_val[31] ? K_DWRITE : K_DREAD, 16'h0, addr, 16'(r_dat),
                 1'b0, 16'h0, 16'h0);
      end
   endtask

   task automatic wait_idle(output bit ok);
      ok = 1'b0;
      for (int n = 0; n < 200; n++) begin
         @(negedge clk);
         if (!i_busy && !d_busy) begin
            ok = 1'b1;
            break;
         end
      end
   endtask

   task automatic apply_row(input row_t r);
      cur = r;
      case (r.kind)
         K_IFETCH: i_addr = r.iaddr;
         K_DREAD: begin
            d_addr   = r.daddr;
            d_mem_en = 1'b1;
         end
         K_DWRITE: begin
            d_addr   = r.daddr;
            d_wdata  = r.wdata;
            d_mem_en = 1'b1;
            d_wrt_en = 1'b1;
         end
         default: begin                  // both caches miss together
            i_addr   = r.iaddr;
            d_addr   = r.daddr;
            d_mem_en = 1'b1;
         end
      endcase
   endtask

   initial begin
      rst_n    = 1'b0;
      i_addr   = '0;
      d_addr   = '0;
      d_wdata  = '0;
      d_mem_en = 1'b0;
      d_wrt_en = 1'b0;
      chk_stb  = 1'b0;
      chk_done = 1'b0;
      cur      = '0;
      hung     = 1'b0;
      seed     = 38;
      build_table();
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      wait_idle(idle);                  // icache fills address 0 after reset
      if (!idle) begin
         $display("caches still busy 200 cycles after reset");
         hung = 1'b1;
      end
      for (int i = 0; i < rows.size() && !hung; i++) begin
         @(posedge clk);
         #1 apply_row(rows[i]);
         wait_idle(idle);
         if (!idle) begin
            $display("test %0s hung with busy high for 200 cycles", rows[i].name);
            hung = 1'b1;
         end else begin
            @(posedge clk);
            #1 chk_stb = 1'b1;
            @(posedge clk);
            #1 chk_stb = 1'b0;
            d_mem_en = 1'b0;
            d_wrt_en = 1'b0;
         end
      end
      if (!hung) begin
         @(posedge clk);
         #1 chk_done = 1'b1;
         @(posedge clk);
         #1 chk_done = 1'b0;
      end
      if (!hung && fail_cnt == 0 && pass_cnt == rows.size()) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- sim.f
mem_pkg.sv
icache.sv
dcache.sv
mem_arbiter.sv
main_memory.sv
memory.sv
memory_assertions.sv
memory_checker.sv
tb_memory.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_memory
FILELIST = sim.f
PASS_MSG = Test OK

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf obj_dir
